// File: Bender.yml
package:
  name: shared_mask_mem

sources:
  # RTL, package first
  - files:
      - hdl/mask_mem_pkg.sv
      - hdl/ram_1r1w_sync.sv
      - hdl/mask_mem_1rw_from_1r1w.sv
      - hdl/rr_client_arbiter.sv
      - hdl/shared_mask_mem_top.sv

  # Testbench, simulation only
  - target: simulation
    include_dirs:
      - tb
    files:
      - tb/tb_shared_mask_mem.sv

// File: hdl/mask_mem_1rw_from_1r1w.sv
//////////////////////////////
// Single-port memory with bit-masked writes on top of a 1R1W RAM
// A masked write is a read-modify-write over two cycles
// Back-to-back hazards on one address go through a bypass register
// Read data is valid one cycle after the access
//////////////////////////////

`timescale 1ns/1ps

module mask_mem_1rw_from_1r1w
  import mask_mem_pkg::*;
(
  input  logic              clk_i,
  input  logic              rst_i,

  // Access port, always ready
  input  logic              v_i,
  input  logic              w_i,
  input  logic [addr_w-1:0] addr_i,
  input  logic [word_w-1:0] mask_i,
  input  logic [word_w-1:0] data_i,

  // Read data, one cycle after a read access
  output logic [word_w-1:0] data_o
);

  // Write accepted this cycle
  logic              wr_now;

  // Pending write from the previous cycle
  logic              pend_r;
  logic [addr_w-1:0] w_addr_r;
  logic [word_w-1:0] mask_r;

  // Current access hits the pending write
  logic              addr_hit;
  logic              byp_n;

  // Previous access hit the write before it
  logic              byp_r;

  // Running value for the address of the pending write
  // Holds new data when there was no hazard, merged word otherwise
  logic [word_w-1:0] byp_data_r;
  logic [word_w-1:0] byp_data_n;

  // RAM side
  logic              ram_wv;
  logic [word_w-1:0] ram_wdata;
  logic              ram_rv;
  logic [word_w-1:0] ram_rdata;

  assign wr_now   = v_i & w_i;
  assign addr_hit = (addr_i == w_addr_r);
  assign byp_n    = pend_r & addr_hit;

  // Pending write flag and bypass flag
  always_ff @(posedge clk_i)
  begin
    if (rst_i)
    begin
      pend_r <= 1'b0;
      byp_r  <= 1'b0;
    end
    else
    begin
      pend_r <= wr_now;
      // Only refreshed on an access
      // Consumers only look at it the cycle after an access
      if (v_i)
        byp_r <= byp_n;
    end
  end

  // Address tracks every access, used for the next hit compare
  always_ff @(posedge clk_i)
  begin
    if (v_i)
      w_addr_r <= addr_i;
  end

  // Mask of the write that is now pending
  always_ff @(posedge clk_i)
  begin
    if (wr_now)
      mask_r <= mask_i;
  end

  // Merged word for the pending write
  // After a hazard the register already has the full running value
  // Otherwise take the fresh RAM word where the mask is 0
  assign ram_wdata = byp_r ? byp_data_r
                           : (ram_rdata & ~mask_r) | (byp_data_r & mask_r);

  // Next bypass value
  always_comb
  begin
    if (byp_n)
    begin
      if (w_i)
        // Write after write, fold the new write into the running word
        byp_data_n = (ram_wdata & ~mask_i) | (data_i & mask_i);
      else
        // Read after write, keep the merged word for data_o
        byp_data_n = ram_wdata;
    end
    else
    begin
      // No hazard, just keep the new data for next cycle's merge
      byp_data_n = data_i;
    end
  end

  always_ff @(posedge clk_i)
  begin
    byp_data_r <= byp_data_n;
  end

  // RAM read is skipped when the word lives in the bypass path
  assign ram_rv = v_i & ~byp_n;

  // Drop the pending RAM write if a new write to the same address overtakes it
  assign ram_wv = pend_r & ~(wr_now & addr_hit);

  ram_1r1w_sync ram_i (
    .clk_i    (clk_i),
    .w_v_i    (ram_wv),
    .w_addr_i (w_addr_r),
    .w_data_i (ram_wdata),
    .r_v_i    (ram_rv),
    .r_addr_i (addr_i),
    .r_data_o (ram_rdata)
  );

  // Return the bypass word after a hazard, else the RAM word
  assign data_o = byp_r ? byp_data_r : ram_rdata;

endmodule

// File: hdl/mask_mem_pkg.sv
//////////////////////////////
// Shared sizes for the masked-write memory and its arbiter
// Imported by every RTL module and by the testbench
//////////////////////////////

package mask_mem_pkg;

  // Data word width, also the write mask width
  // One mask bit per data bit
  localparam int word_w = 32;

  // Number of words in the memory
  localparam int mem_depth = 64;

  // Address width follows from the depth
  localparam int addr_w = $clog2(mem_depth);

  // Peer clients sharing the memory
  localparam int num_clients = 3;

  // Width of a client index
  // Must hold num_clients-1
  localparam int client_w = 2;

endpackage

// File: hdl/ram_1r1w_sync.sv
//////////////////////////////
// Simple dual-port RAM, one write port and one read port
// Read data is registered and appears one cycle after r_v_i
//////////////////////////////

`timescale 1ns/1ps

module ram_1r1w_sync
  import mask_mem_pkg::*;
(
  input  logic              clk_i,

  // Write port
  input  logic              w_v_i,
  input  logic [addr_w-1:0] w_addr_i,
  input  logic [word_w-1:0] w_data_i,

  // Read port
  input  logic              r_v_i,
  input  logic [addr_w-1:0] r_addr_i,
  output logic [word_w-1:0] r_data_o
);

  // Storage array, contents undefined until written
  logic [word_w-1:0] mem [mem_depth];

  // Write on the clock edge
  always_ff @(posedge clk_i)
  begin
    if (w_v_i)
      mem[w_addr_i] <= w_data_i;
  end

  // Registered read
  // Output holds its last value on idle cycles
  always_ff @(posedge clk_i)
  begin
    if (r_v_i)
      r_data_o <= mem[r_addr_i];
  end

endmodule

// File: hdl/rr_client_arbiter.sv
//////////////////////////////
// Round-robin arbiter for the clients of the shared memory
// Grants one request per cycle, combinationally
// Steers the read return to the winner one cycle later
//////////////////////////////

`timescale 1ns/1ps

module rr_client_arbiter
  import mask_mem_pkg::*;
(
  input  logic                                  clk_i,
  input  logic                                  rst_i,

  // Client requests, indexed by client number
  input  logic [num_clients-1:0]                req_valid_i,
  input  logic [num_clients-1:0]                req_write_i,
  input  logic [num_clients-1:0][addr_w-1:0]    req_addr_i,
  input  logic [num_clients-1:0][word_w-1:0]    req_mask_i,
  input  logic [num_clients-1:0][word_w-1:0]    req_wdata_i,
  output logic [num_clients-1:0]                req_ready_o,

  // Client returns, fixed one-cycle latency
  output logic [num_clients-1:0]                rsp_valid_o,
  output logic [word_w-1:0]                     rsp_rdata_o,

  // Memory port
  output logic                                  mem_v_o,
  output logic                                  mem_w_o,
  output logic [addr_w-1:0]                     mem_addr_o,
  output logic [word_w-1:0]                     mem_mask_o,
  output logic [word_w-1:0]                     mem_wdata_o,
  input  logic [word_w-1:0]                     mem_rdata_i
);

  // Round-robin pointer, client with top priority this cycle
  logic [client_w-1:0] ptr_r;

  // Winner of this cycle
  logic                win_found;
  logic [client_w-1:0] win_idx;

  // Registered winner and read flag for the return
  logic [client_w-1:0] win_r;
  logic                rd_r;

  // Scan from the pointer, first requester wins
  always_comb
  begin
    int unsigned cand;
    win_found = 1'b0;
    win_idx   = '0;
    for (int i = 0; i < num_clients; i++)
    begin
      cand = (int'(ptr_r) + i) % num_clients;
      if (!win_found && req_valid_i[cand])
      begin
        win_found = 1'b1;
        win_idx   = cand[client_w-1:0];
      end
    end
  end

  // One-hot ready, only for the winner
  always_comb
  begin
    req_ready_o = '0;
    if (win_found)
      req_ready_o[win_idx] = 1'b1;
  end

  // Winner fields onto the memory port
  assign mem_v_o     = win_found;
  assign mem_w_o     = req_write_i[win_idx];
  assign mem_addr_o  = req_addr_i[win_idx];
  assign mem_mask_o  = req_mask_i[win_idx];
  assign mem_wdata_o = req_wdata_i[win_idx];

  // Pointer moves past the winner, wrapping at the last client
  always_ff @(posedge clk_i)
  begin
    if (rst_i)
      ptr_r <= '0;
    else if (win_found)
      ptr_r <= (win_idx == client_w'(num_clients - 1)) ? '0 : win_idx + 1'b1;
  end

  // Remember who gets the read return
  always_ff @(posedge clk_i)
  begin
    if (rst_i)
    begin
      rd_r  <= 1'b0;
      win_r <= '0;
    end
    else
    begin
      rd_r  <= win_found & ~req_write_i[win_idx];
      win_r <= win_idx;
    end
  end

  // Return pulse to the client of last cycle's read
  // Writes produce no return
  always_comb
  begin
    rsp_valid_o = '0;
    if (rd_r)
      rsp_valid_o[win_r] = 1'b1;
  end

  // Shared return data, qualified by rsp_valid_o
  assign rsp_rdata_o = mem_rdata_i;

endmodule

// File: hdl/shared_mask_mem_top.sv
//////////////////////////////
// Masked-write memory shared by three clients
// Arbiter in front, read-modify-write memory behind it
//////////////////////////////

`timescale 1ns/1ps

module shared_mask_mem_top
  import mask_mem_pkg::*;
(
  input  logic                                  clk_i,
  input  logic                                  rst_i,

  // Client requests
  input  logic [num_clients-1:0]                req_valid_i,
  input  logic [num_clients-1:0]                req_write_i,
  input  logic [num_clients-1:0][addr_w-1:0]    req_addr_i,
  input  logic [num_clients-1:0][word_w-1:0]    req_mask_i,
  input  logic [num_clients-1:0][word_w-1:0]    req_wdata_i,
  output logic [num_clients-1:0]                req_ready_o,

  // Client returns
  output logic [num_clients-1:0]                rsp_valid_o,
  output logic [word_w-1:0]                     rsp_rdata_o
);

  // Arbiter to memory
  logic              mem_v;
  logic              mem_w;
  logic [addr_w-1:0] mem_addr;
  logic [word_w-1:0] mem_mask;
  logic [word_w-1:0] mem_wdata;

  // Memory to arbiter, one cycle after a read
  logic [word_w-1:0] mem_rdata;

  rr_client_arbiter arb_i (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .req_valid_i (req_valid_i),
    .req_write_i (req_write_i),
    .req_addr_i  (req_addr_i),
    .req_mask_i  (req_mask_i),
    .req_wdata_i (req_wdata_i),
    .req_ready_o (req_ready_o),
    .rsp_valid_o (rsp_valid_o),
    .rsp_rdata_o (rsp_rdata_o),
    .mem_v_o     (mem_v),
    .mem_w_o     (mem_w),
    .mem_addr_o  (mem_addr),
    .mem_mask_o  (mem_mask),
    .mem_wdata_o (mem_wdata),
    .mem_rdata_i (mem_rdata)
  );

  // Memory never stalls, so no ready back to the arbiter
  mask_mem_1rw_from_1r1w mem_i (
    .clk_i  (clk_i),
    .rst_i  (rst_i),
    .v_i    (mem_v),
    .w_i    (mem_w),
    .addr_i (mem_addr),
    .mask_i (mem_mask),
    .data_i (mem_wdata),
    .data_o (mem_rdata)
  );

endmodule

// File: sim.f
+incdir+tb
hdl/mask_mem_pkg.sv
hdl/ram_1r1w_sync.sv
hdl/mask_mem_1rw_from_1r1w.sv
hdl/rr_client_arbiter.sv
hdl/shared_mask_mem_top.sv
tb/tb_shared_mask_mem.sv

// File: tb/tb_ref_model.svh
//////////////////////////////
// Reference model for the shared masked-write memory testbench
// Included inside the testbench module after its signal declarations
//////////////////////////////

`ifndef TB_REF_MODEL_SVH
`define TB_REF_MODEL_SVH

// Generator seed and LCG constants
localparam logic [31:0] lcg_seed = 32'h24e4_206d;
localparam logic [31:0] lcg_mul  = 32'd1664525;
localparam logic [31:0] lcg_inc  = 32'd1013904223;

// Expected memory contents, X until first written
logic [word_w-1:0] ref_mem [mem_depth];

// Pointer of the reference arbiter
int ref_ptr;

// Generator state
logic [31:0] rng_state = lcg_seed;

// Mask bit 1 takes the new bit and mask bit 0 keeps the old bit
function automatic logic [word_w-1:0] merge_word(
  input logic [word_w-1:0] old_word,
  input logic [word_w-1:0] mask,
  input logic [word_w-1:0] new_word
);
  return (old_word & ~mask) | (new_word & mask);
endfunction

// Expected winner, first requester at or after the pointer
// Returns -1 when nobody requests
function automatic int rr_pick(input int ptr, input logic [num_clients-1:0] req);
  int idx;
  int win;
  win = -1;
  for (int i = 0; i < num_clients; i++)
  begin
    idx = (ptr + i) % num_clients;
    if (win < 0 && req[idx])
      win = idx;
  end
  return win;
endfunction

// Next value of the linear congruential generator
function automatic logic [31:0] lcg_next();
  rng_state = rng_state * lcg_mul + lcg_inc;
  return rng_state;
endfunction

`endif

// File: tb/tb_shared_mask_mem.sv
//////////////////////////////
// Testbench for the shared masked-write memory
// Client drivers, a monitor with reference model, a return checker
//////////////////////////////

`timescale 1ns/1ps

module tb_shared_mask_mem
  import mask_mem_pkg::*;
();

  localparam int timeout_cycles = 200;
  localparam int rand_count     = 40;
  localparam int clk_period     = 100;

  logic                               clk_i;
  logic                               rst_i;
  logic [num_clients-1:0]             req_valid;
  logic [num_clients-1:0]             req_write;
  logic [num_clients-1:0][addr_w-1:0] req_addr;
  logic [num_clients-1:0][word_w-1:0] req_mask;
  logic [num_clients-1:0][word_w-1:0] req_wdata;
  logic [num_clients-1:0]             req_ready;
  logic [num_clients-1:0]             rsp_valid;
  logic [word_w-1:0]                  rsp_rdata;

  // Expected read data per client, in acceptance order
  logic [word_w-1:0] exp_q [num_clients][$];

  // Acceptance time of each outstanding read
  time acc_q [num_clients][$];

  // Bookkeeping for the report
  int err_count;
  int check_count;
  int err_mark;
  int test_num;
  int tests_failed;
  int max_wait [num_clients];

  `include "tb_ref_model.svh"

  shared_mask_mem_top dut_i (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .req_valid_i (req_valid),
    .req_write_i (req_write),
    .req_addr_i  (req_addr),
    .req_mask_i  (req_mask),
    .req_wdata_i (req_wdata),
    .req_ready_o (req_ready),
    .rsp_valid_o (rsp_valid),
    .rsp_rdata_o (rsp_rdata)
  );

  // 100 ns clock
  initial
  begin
    clk_i = 1'b0;
    forever #(clk_period / 2) clk_i = ~clk_i;
  end

  task automatic check_value(input string name, input logic [word_w-1:0] got,
                             input logic [word_w-1:0] exp);
    check_count++;
    if (got !== exp)
    begin
      err_count++;
      $display("[ERROR] %0t ns %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic abort_timeout(input string what);
    $display("Timeout after %0d cycles waiting for %s", timeout_cycles, what);
    $display("TB FAILED");
    $finish;
  endtask

  // Called on a rising edge, returns on the edge of acceptance
  task automatic send_req(input int c, input logic wr, input logic [addr_w-1:0] addr,
                          input logic [word_w-1:0] mask, input logic [word_w-1:0] data);
    int   cnt;
    logic done;
    req_valid[c] <= 1'b1;
    req_write[c] <= wr;
    req_addr[c]  <= addr;
    req_mask[c]  <= mask;
    req_wdata[c] <= data;
    cnt  = 0;
    done = 1'b0;
    while (!done)
    begin
      @(posedge clk_i);
      cnt++;
      if (req_ready[c])
        done = 1'b1;
      else if (cnt > timeout_cycles)
        abort_timeout($sformatf("a grant to client %0d", c));
    end
    if (cnt > max_wait[c])
      max_wait[c] = cnt;
  endtask

  task automatic drop_valid(input int c);
    req_valid[c] <= 1'b0;
  endtask

  function automatic int pending_reads();
    int n;
    n = 0;
    for (int c = 0; c < num_clients; c++)
      n += exp_q[c].size();
    return n;
  endfunction

  // Queues are looked at on the falling edge where they are stable
  task automatic wait_drain();
    int cnt;
    cnt = 0;
    @(negedge clk_i);
    while (pending_reads() != 0)
    begin
      cnt++;
      if (cnt > timeout_cycles)
        abort_timeout("outstanding read returns");
      @(negedge clk_i);
    end
    @(posedge clk_i);
  endtask

  // Random reads and masked writes, optional idle gaps between them
  task automatic run_random(input int c, input int n, input logic [addr_w-1:0] addr_bits,
                            input logic gaps);
    logic [31:0] r;
    for (int i = 0; i < n; i++)
    begin
      r = lcg_next();
      if (gaps && r[1:0] == 2'd0)
      begin
        drop_valid(c);
        @(posedge clk_i);
      end
      send_req(c, r[8], r[addr_w+15:16] & addr_bits, lcg_next(), lcg_next());
    end
    drop_valid(c);
  endtask

  task automatic report_test(input string name);
    int errs;
    errs     = err_count - err_mark;
    err_mark = err_count;
    test_num++;
    if (errs != 0)
      tests_failed++;
    $display("Test %0d (%s) done with %0d errors", test_num, name, errs);
  endtask

  // Monitor, checks the grant and updates the reference model
  always @(posedge clk_i)
  begin : monitor
    int                     win;
    logic [num_clients-1:0] exp_ready;
    if (rst_i)
      ref_ptr = 0;
    else
    begin
      win       = rr_pick(ref_ptr, req_valid);
      exp_ready = '0;
      if (win >= 0)
      begin
        exp_ready[win] = 1'b1;
        ref_ptr        = (win + 1) % num_clients;
      end
      check_value("req_ready_o", req_ready, exp_ready);
      for (int c = 0; c < num_clients; c++)
      begin
        if (req_valid[c] && req_ready[c])
        begin
          if (req_write[c])
            ref_mem[req_addr[c]] = merge_word(ref_mem[req_addr[c]], req_mask[c], req_wdata[c]);
          else
          begin
            exp_q[c].push_back(ref_mem[req_addr[c]]);
            acc_q[c].push_back($time);
          end
        end
      end
    end
  end

  // Return checker, one pulse per accepted read, one cycle after acceptance
  always @(posedge clk_i)
  begin : compare
    logic [word_w-1:0] exp_data;
    time               acc_time;
    if (!rst_i)
    begin
      for (int c = 0; c < num_clients; c++)
      begin
        if (rsp_valid[c])
        begin
          if (exp_q[c].size() == 0)
          begin
            err_count++;
            $display("Client %0d got a read return with no read outstanding at %0t ns",
                     c, $time);
          end
          else
          begin
            exp_data = exp_q[c].pop_front();
            acc_time = acc_q[c].pop_front();
            if ($time - acc_time != clk_period)
            begin
              err_count++;
              $display("Client %0d got a read return %0t ns after acceptance, not one cycle",
                       c, $time - acc_time);
            end
            check_value($sformatf("rsp_rdata_o[%0d]", c), rsp_rdata, exp_data);
          end
        end
      end
    end
  end

  initial
  begin : main
    logic [31:0]       r;
    logic [addr_w-1:0] a;
    int                n;
    rst_i     = 1'b1;
    req_valid = '0;
    req_write = '0;
    req_addr  = '0;
    req_mask  = '0;
    req_wdata = '0;
    repeat (2) @(posedge clk_i);
    rst_i <= 1'b0;

    // Fill every word with a full mask, then read it all back
    for (int i = 0; i < mem_depth; i++)
      send_req(0, 1'b1, addr_w'(i), '1, lcg_next());
    for (int i = 0; i < mem_depth; i++)
      send_req(0, 1'b0, addr_w'(i), '0, '0);
    drop_valid(0);
    wait_drain();
    report_test("init and readback");

    // Isolated masked writes, read after idle cycles
    for (int i = 0; i < 20; i++)
    begin
      r = lcg_next();
      a = r[addr_w-1:0];
      send_req(i % num_clients, 1'b1, a, lcg_next(), lcg_next());
      drop_valid(i % num_clients);
      repeat (3) @(posedge clk_i);
      send_req(i % num_clients, 1'b0, a, '0, '0);
      drop_valid(i % num_clients);
      repeat (3) @(posedge clk_i);
    end
    wait_drain();
    report_test("partial mask merge");

    // Two or three back-to-back writes to one address
    for (int i = 0; i < 12; i++)
    begin
      r = lcg_next();
      a = r[addr_w-1:0];
      n = 2 + r[8];
      for (int k = 0; k < n; k++)
        send_req(1, 1'b1, a, lcg_next(), lcg_next());
      drop_valid(1);
      repeat (2) @(posedge clk_i);
      send_req(1, 1'b0, a, '0, '0);
      drop_valid(1);
      repeat (2) @(posedge clk_i);
    end
    wait_drain();
    report_test("write after write");

    // Read on the edge after the write, repeated after idle cycles
    for (int i = 0; i < 12; i++)
    begin
      r = lcg_next();
      a = r[addr_w-1:0];
      send_req(2, 1'b1, a, lcg_next(), lcg_next());
      send_req(2, 1'b0, a, '0, '0);
      drop_valid(2);
      repeat (3) @(posedge clk_i);
      send_req(2, 1'b0, a, '0, '0);
      drop_valid(2);
      repeat (2) @(posedge clk_i);
    end
    wait_drain();
    report_test("read after write");

    // All clients hold valid high continuously
    for (int c = 0; c < num_clients; c++)
      max_wait[c] = 0;
    fork
      run_random(0, 8, '1, 1'b0);
      run_random(1, 8, '1, 1'b0);
      run_random(2, 8, '1, 1'b0);
    join
    wait_drain();
    for (int c = 0; c < num_clients; c++)
    begin
      if (max_wait[c] > num_clients)
      begin
        err_count++;
        $display("Client %0d waited %0d cycles for a grant", c, max_wait[c]);
      end
    end
    report_test("round-robin arbitration");

    // Four addresses only, so hazards are frequent
    fork
      run_random(0, rand_count, addr_w'(3), 1'b1);
      run_random(1, rand_count, addr_w'(3), 1'b1);
      run_random(2, rand_count, addr_w'(3), 1'b1);
    join
    wait_drain();
    report_test("mixed random traffic");

    $display("Summary %0d tests, %0d failed, %0d checks, %0d errors",
             test_num, tests_failed, check_count, err_count);
    if (err_count == 0)
      $display("TB PASSED");
    else
      $display("TB FAILED");
    $finish;
  end

endmodule
